/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_tcdm_subsystem
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation runs from the project root so the trace path resolves
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb.f */
verilog/tcdm_pkg.sv
verilog/tcdm_rr_arbiter.sv
verilog/tcdm_r_id_filter.sv
verilog/tcdm_sram_bank.sv
verilog/tcdm_subsystem_top.sv
testbench/tcdm_checker.sv
testbench/tb_tcdm_subsystem.sv

/* testbench/tb_tcdm_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_subsystem;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // DUT signals and trace storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic                                        clk_i;
  logic                                        rst_ni;
  logic                                        clear;
  tcdm_pkg::tcdm_req_t [tcdm_pkg::NumInit-1:0] init_req;
  tcdm_pkg::tcdm_rsp_t [tcdm_pkg::NumInit-1:0] init_rsp;

  tcdm_pkg::tcdm_rsp_t [tcdm_pkg::NumInit-1:0] exp_rsp;   // expected responses of this cycle
  logic                                        check_en;  // high while trace lines are applied
  int unsigned                                 line_no;   // trace file line of this cycle
  int unsigned                                 gnt_errors;
  int unsigned                                 valid_errors;
  int unsigned                                 data_errors;
  int unsigned                                 id_errors;
  logic                                        trace_ready;  // trace is loaded and the run starts

  logic                                        clear_q    [$];  // clear per cycle
  tcdm_pkg::tcdm_req_t [tcdm_pkg::NumInit-1:0] stim_q     [$];  // requests per cycle
  tcdm_pkg::tcdm_rsp_t [tcdm_pkg::NumInit-1:0] exp_q      [$];  // expected responses per cycle
  int unsigned                                 src_line_q [$];  // file line of each entry

  tcdm_subsystem_top i_tcdm_subsystem_top (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear    (clear),
    .init_req (init_req),
    .init_rsp (init_rsp)
  );

  tcdm_checker i_tcdm_checker (
    .clk_i        (clk_i),
    .check_en     (check_en),
    .line_no      (line_no),
    .dut_rsp      (init_rsp),
    .exp_rsp      (exp_rsp),
    .gnt_errors   (gnt_errors),
    .valid_errors (valid_errors),
    .data_errors  (data_errors),
    .id_errors    (id_errors)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;  // 10 ns period
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // trace loading
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // each data line holds 17 hex fields and lines starting with # are notes
  task automatic load_trace(output bit ok);
    int                                          fd;
    int                                          n;
    int unsigned                                 file_line;
    string                                       text;
    logic [31:0]                                 v [17];
    tcdm_pkg::tcdm_req_t [tcdm_pkg::NumInit-1:0] stim;
    tcdm_pkg::tcdm_rsp_t [tcdm_pkg::NumInit-1:0] expv;
    ok        = 1'b1;
    file_line = 0;
    fd        = $fopen("testbench/tcdm_trace.txt", "r");
    if (fd == 0) begin
      $display("the trace file testbench/tcdm_trace.txt could not be opened");
      ok = 1'b0;
      return;
    end
    while ($fgets(text, fd) != 0) begin
      file_line++;
      if (text[0] != "#" && text[0] != "\n") begin
        n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                    v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
        if (n != 17) begin
          $display("trace line %0d holds %0d fields instead of 17", file_line, n);
          ok = 1'b0;
        end else begin
          stim            = '0;
          expv            = '0;  // r_id is not part of the trace
          stim[0].req     = v[1][0];
          stim[0].wen     = v[2][0];
          stim[0].add     = tcdm_pkg::addr_t'(v[3]);
          stim[0].data    = v[4];
          stim[0].be      = tcdm_pkg::be_t'(v[5]);
          stim[1].req     = v[6][0];
          stim[1].wen     = v[7][0];
          stim[1].add     = tcdm_pkg::addr_t'(v[8]);
          stim[1].data    = v[9];
          stim[1].be      = tcdm_pkg::be_t'(v[10]);
          expv[0].gnt     = v[11][0];
          expv[1].gnt     = v[12][0];
          expv[0].r_valid = v[13][0];
          expv[0].r_data  = v[14];
          expv[1].r_valid = v[15][0];
          expv[1].r_data  = v[16];
          clear_q.push_back(v[0][0]);
          stim_q.push_back(stim);
          exp_q.push_back(expv);
          src_line_q.push_back(file_line);
        end
      end
    end
    $fclose(fd);
    if (stim_q.size() == 0) begin
      $display("the trace file holds no data lines");
      ok = 1'b0;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : stimulus
    bit          loaded;
    int unsigned total;
    rst_ni      = 1'b0;
    clear       = 1'b0;
    init_req    = '0;
    exp_rsp     = '0;
    check_en    = 1'b0;
    line_no     = 0;
    trace_ready = 1'b0;
    load_trace(loaded);
    if (!loaded) begin
      $display("the trace could not be loaded and no cycle was run");
      $display("Test failed");
      $finish;
    end else begin
      trace_ready = 1'b1;
      repeat (2) @(posedge clk_i);  // reset held for two cycles
      rst_ni <= 1'b1;
      for (int i = 0; i < stim_q.size(); i++) begin
        @(posedge clk_i);
        clear    <= clear_q[i];
        init_req <= stim_q[i];
        exp_rsp  <= exp_q[i];
        line_no  <= src_line_q[i];
        check_en <= 1'b1;
      end
      @(posedge clk_i);  // last line was compared on the falling edge before this
      check_en <= 1'b0;
      init_req <= '0;
      clear    <= 1'b0;
      @(posedge clk_i);
      total = gnt_errors + valid_errors + data_errors + id_errors;
      $display("errors: gnt %0d, r_valid %0d, r_data %0d, r_id %0d, total %0d",
               gnt_errors, valid_errors, data_errors, id_errors, total);
      if (total == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

  // the limit grows with the trace length plus reset and a margin
  initial begin : watchdog
    int unsigned limit;
    wait (trace_ready);
    limit = stim_q.size() + 2 + 20;
    repeat (limit) @(posedge clk_i);
    $display("timeout: the run did not end within %0d cycles", limit);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tcdm_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tcdm_checker (
  input  logic                                        clk_i,
  input  logic                                        check_en,
  input  int unsigned                                 line_no,
  input  tcdm_pkg::tcdm_rsp_t [tcdm_pkg::NumInit-1:0] dut_rsp,
  input  tcdm_pkg::tcdm_rsp_t [tcdm_pkg::NumInit-1:0] exp_rsp,
  output int unsigned                                 gnt_errors,
  output int unsigned                                 valid_errors,
  output int unsigned                                 data_errors,
  output int unsigned                                 id_errors
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // error counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  int unsigned gnt_cnt   = 0;  // wrong grants seen so far
  int unsigned valid_cnt = 0;  // wrong r_valid seen so far
  int unsigned data_cnt  = 0;  // wrong read data seen so far
  int unsigned id_cnt    = 0;  // wrong response tags seen so far

  assign gnt_errors   = gnt_cnt;
  assign valid_errors = valid_cnt;
  assign data_errors  = data_cnt;
  assign id_errors    = id_cnt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per cycle comparison
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // inputs change just after the rising edge so the falling edge sees settled values
  always @(negedge clk_i) begin : compare
    if (check_en) begin
      for (int i = 0; i < tcdm_pkg::NumInit; i++) begin
        if (dut_rsp[i].gnt !== exp_rsp[i].gnt) begin
          $display("CHECK FAILED trace line %0d init_rsp[%0d].gnt expected %h actual %h",
                   line_no, i, exp_rsp[i].gnt, dut_rsp[i].gnt);
          gnt_cnt++;  // grant went to the wrong side or was missing
        end
        if (dut_rsp[i].r_valid !== exp_rsp[i].r_valid) begin
          $display("CHECK FAILED trace line %0d init_rsp[%0d].r_valid expected %h actual %h",
                   line_no, i, exp_rsp[i].r_valid, dut_rsp[i].r_valid);
          valid_cnt++;  // response routed wrongly or at the wrong time
        end
        // r_data carries nothing while r_valid is low
        if (exp_rsp[i].r_valid && (dut_rsp[i].r_data !== exp_rsp[i].r_data)) begin
          $display("CHECK FAILED trace line %0d init_rsp[%0d].r_data expected %h actual %h",
                   line_no, i, exp_rsp[i].r_data, dut_rsp[i].r_data);
          data_cnt++;  // memory content or write response is off
        end
        // a valid response carries the index of the initiator that receives it
        if (exp_rsp[i].r_valid && (dut_rsp[i].r_id !== tcdm_pkg::id_t'(i))) begin
          $display("CHECK FAILED trace line %0d init_rsp[%0d].r_id expected %h actual %h",
                   line_no, i, tcdm_pkg::id_t'(i), dut_rsp[i].r_id);
          id_cnt++;  // tag returned to the initiator does not match it
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tcdm_trace.txt */
# clr | req wen add data be (init 0) | req wen add data be (init 1) | gnt0 gnt1 | rv0 rdata0 | rv1 rdata1
# all fields are hex, wen is 1 for a read, one line per clock cycle after reset
0  0 0 00 00000000 0  0 0 00 00000000 0  0 0  0 00000000  0 00000000
0  0 0 00 00000000 0  0 0 00 00000000 0  0 0  0 00000000  0 00000000
0  1 0 10 deadbeef f  0 0 00 00000000 0  1 0  0 00000000  0 00000000
0  1 1 10 00000000 0  0 0 00 00000000 0  1 0  1 00000000  0 00000000
0  0 0 00 00000000 0  0 0 00 00000000 0  0 0  1 deadbeef  0 00000000
0  0 0 00 00000000 0  1 0 20 11223344 f  0 1  0 00000000  0 00000000
0  0 0 00 00000000 0  1 0 20 aabbccdd 5  0 1  0 00000000  1 00000000
0  0 0 00 00000000 0  1 1 20 00000000 0  0 1  0 00000000  1 00000000
0  0 0 00 00000000 0  0 0 00 00000000 0  0 0  0 00000000  1 11bb33dd
0  1 0 10 12345678 8  0 0 00 00000000 0  1 0  0 00000000  0 00000000
0  1 1 10 00000000 0  0 0 00 00000000 0  1 0  1 00000000  0 00000000
0  0 0 00 00000000 0  0 0 00 00000000 0  0 0  1 12adbeef  0 00000000
0  1 0 30 a0a0a0a0 f  1 0 31 b1b1b1b1 f  0 1  0 00000000  0 00000000
0  1 0 30 a0a0a0a0 f  1 0 32 b2b2b2b2 f  1 0  0 00000000  1 00000000
0  1 0 33 a3a3a3a3 f  1 0 32 b2b2b2b2 f  0 1  1 00000000  0 00000000
0  1 0 33 a3a3a3a3 f  1 1 31 00000000 0  1 0  0 00000000  1 00000000
0  1 1 30 00000000 0  1 1 31 00000000 0  0 1  1 00000000  0 00000000
0  1 1 30 00000000 0  1 1 32 00000000 0  1 0  0 00000000  1 b1b1b1b1
0  1 1 33 00000000 0  1 1 32 00000000 0  0 1  1 a0a0a0a0  0 00000000
0  1 1 33 00000000 0  0 0 00 00000000 0  1 0  0 00000000  1 b2b2b2b2
0  0 0 00 00000000 0  0 0 00 00000000 0  0 0  1 a3a3a3a3  0 00000000
1  0 0 00 00000000 0  0 0 00 00000000 0  0 0  0 00000000  0 00000000
0  1 1 10 00000000 0  1 1 20 00000000 0  1 0  0 00000000  0 00000000
0  0 0 00 00000000 0  1 1 20 00000000 0  0 1  1 12adbeef  0 00000000
0  0 0 00 00000000 0  0 0 00 00000000 0  0 0  0 00000000  1 11bb33dd
0  0 0 00 00000000 0  0 0 00 00000000 0  0 0  0 00000000  0 00000000

/* verilog/tcdm_pkg.sv */
`default_nettype none

package tcdm_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // subsystem sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned NumInit   = 2;              // initiators sharing the single bank
  localparam int unsigned AddrWidth = 8;              // word address bits of the bank
  localparam int unsigned DataWidth = 32;             // one memory word
  localparam int unsigned BeWidth   = DataWidth / 8;  // one enable per byte lane

  // the id carries the index of the initiator that issued a request
  localparam int unsigned IdWidth   = (NumInit > 1) ? $clog2(NumInit) : 1;

  localparam int unsigned NumWords  = 2 ** AddrWidth;  // depth of the bank in words

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // field types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [IdWidth-1:0]   id_t;    // initiator index as it travels with a request
  typedef logic [AddrWidth-1:0] addr_t;  // word address, no byte offset bits
  typedef logic [DataWidth-1:0] data_t;  // write data and read data
  typedef logic [BeWidth-1:0]   be_t;    // byte enables of a write

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request and response bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // request channel from an initiator toward the bank
  // all fields stay stable while req is high and gnt is still low
  typedef struct packed {
    logic  req;   // a transfer is pending
    logic  wen;   // high for a read and low for a write
    addr_t add;   // word address in the bank
    data_t data;  // write data and ignored on reads
    be_t   be;    // selects the bytes a write updates
    id_t   id;    // initiator tag added by the arbiter
  } tcdm_req_t;

  // response channel from the bank back toward an initiator
  // gnt is combinational and r_valid follows a grant by exactly one cycle
  typedef struct packed {
    logic  gnt;      // request accepted in this cycle
    logic  r_valid;  // response of the request granted one cycle earlier
    data_t r_data;   // read word and zero for a write
    id_t   r_id;     // tag of the initiator the response belongs to
  } tcdm_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // note on latency
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // there is no ready on the response side
  // a response is always taken in the cycle it appears
  // the id filter relies on this fixed one cycle latency

endpackage

`default_nettype wire

/* verilog/tcdm_r_id_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module tcdm_r_id_filter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear,
  input  tcdm_pkg::tcdm_req_t target_req,
  output tcdm_pkg::tcdm_rsp_t target_rsp,
  output tcdm_pkg::tcdm_req_t initiator_req,
  input  tcdm_pkg::tcdm_rsp_t initiator_rsp
);

  // this block must sit where a granted request is answered in the next cycle
  // anywhere else the stored id would be attached to the wrong response

  tcdm_pkg::id_t id_q;  // id of the request forwarded in the previous cycle

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pass through with the id stripped and restored
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin : req_path
    initiator_req    = target_req;  // address, data, enables and handshake unchanged
    initiator_req.id = '0;          // the target never sees the tag
  end

  always_comb begin : rsp_path
    target_rsp      = initiator_rsp;  // gnt, r_valid and r_data flow straight back
    target_rsp.r_id = id_q;           // tag of the request answered in this cycle
  end

  // the id is taken at the edge where the request is presented
  // the bank grants every request so req alone marks an accepted transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin : id_reg
    if (!rst_ni) begin
      id_q <= '0;
    end else if (clear) begin
      id_q <= '0;  // clear drops any stale tag
    end else if (target_req.req) begin
      id_q <= target_req.id;  // held until the next request arrives
    end
  end

  // between requests id_q keeps its old value
  // that is harmless since r_valid is low in those cycles

endmodule

`default_nettype wire

/* verilog/tcdm_rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module tcdm_rr_arbiter (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          clear,
  input  tcdm_pkg::tcdm_req_t [tcdm_pkg::NumInit-1:0]   init_req,
  output tcdm_pkg::tcdm_rsp_t [tcdm_pkg::NumInit-1:0]   init_rsp,
  output tcdm_pkg::tcdm_req_t                           mem_req,
  input  tcdm_pkg::tcdm_rsp_t                           mem_rsp
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // priority pointer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  tcdm_pkg::id_t rr_q;     // initiator with the highest priority in this cycle
  tcdm_pkg::id_t rr_next;  // pointer value after the current grant
  tcdm_pkg::id_t winner;   // initiator picked in this cycle
  logic          any_req;  // at least one initiator is requesting

  // search starts at the pointer and wraps around the initiators
  always_comb begin : winner_search
    int unsigned idx;
    idx     = 0;
    any_req = 1'b0;
    winner  = rr_q;  // default keeps the select stable when nobody requests
    for (int unsigned off = 0; off < tcdm_pkg::NumInit; off++) begin
      idx = (32'(rr_q) + off) % tcdm_pkg::NumInit;  // candidate in rotating order
      if (!any_req && init_req[idx].req) begin
        any_req = 1'b1;  // first requester found from the pointer wins
        winner  = tcdm_pkg::id_t'(idx);
      end
    end
  end

  // the winner drops to lowest priority so the other side goes next
  assign rr_next = (winner == tcdm_pkg::id_t'(tcdm_pkg::NumInit - 1)) ?
                   '0 : tcdm_pkg::id_t'(winner + 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_reg
    if (!rst_ni) begin
      rr_q <= '0;  // initiator 0 is favoured out of reset
    end else if (clear) begin
      rr_q <= '0;  // clear also returns priority to initiator 0
    end else if (mem_rsp.gnt) begin
      rr_q <= rr_next;  // the pointer moves only on an accepted request
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin : req_mux
    mem_req     = init_req[winner];  // fields of the selected initiator
    mem_req.req = any_req;           // valid whenever anyone asks
    mem_req.id  = winner;            // tag so the response can be routed back
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // gnt goes to the winner alone and the loser keeps its request up
  // the response is steered by the id returned from the filter
  always_comb begin : rsp_fanout
    for (int unsigned i = 0; i < tcdm_pkg::NumInit; i++) begin
      init_rsp[i]     = '0;  // idle response for initiators not addressed
      init_rsp[i].gnt = mem_rsp.gnt && (winner == tcdm_pkg::id_t'(i));
      if (mem_rsp.r_valid && (mem_rsp.r_id == tcdm_pkg::id_t'(i))) begin
        init_rsp[i].r_valid = 1'b1;            // response belongs to this initiator
        init_rsp[i].r_data  = mem_rsp.r_data;  // read word or zero for a write
        init_rsp[i].r_id    = mem_rsp.r_id;    // tag is returned unchanged
      end
    end
  end

  // with both initiators requesting every cycle the grants alternate
  // because the pointer always lands on the side that just lost
  // a single requester is served back to back with no idle cycle

endmodule

`default_nettype wire

/* verilog/tcdm_sram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module tcdm_sram_bank (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::tcdm_req_t req,
  output tcdm_pkg::tcdm_rsp_t rsp
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage and response registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  tcdm_pkg::data_t mem_q [tcdm_pkg::NumWords];  // one word per address
  tcdm_pkg::data_t r_data_q;                    // read data of the last request
  logic            r_valid_q;                   // a request was served at the last edge

  // the bank has a single port and serves one access per cycle
  // a read and a write never happen in the same cycle

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory access
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin : mem_access
    if (req.req) begin
      if (req.wen) begin
        r_data_q <= mem_q[req.add];  // read word shows up one cycle later
      end else begin
        r_data_q <= '0;  // a write answers with zero data
        for (int unsigned b = 0; b < tcdm_pkg::BeWidth; b++) begin
          if (req.be[b]) begin
            mem_q[req.add][8*b +: 8] <= req.data[8*b +: 8];  // only enabled lanes change
          end
        end
      end
    end
  end

  // r_valid follows every request by exactly one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req.req;  // reads and writes both get a response
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response assembly
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin : rsp_drive
    rsp         = '0;
    rsp.gnt     = req.req;    // no contention at the bank so every request is granted
    rsp.r_valid = r_valid_q;
    rsp.r_data  = r_data_q;   // only meaningful while r_valid is high
    rsp.r_id    = '0;         // the filter upstream supplies the real tag
  end

endmodule

`default_nettype wire

/* verilog/tcdm_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tcdm_subsystem_top (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          clear,
  input  tcdm_pkg::tcdm_req_t [tcdm_pkg::NumInit-1:0]   init_req,
  output tcdm_pkg::tcdm_rsp_t [tcdm_pkg::NumInit-1:0]   init_rsp
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage links
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  tcdm_pkg::tcdm_req_t arb_req;   // tagged request from the arbiter
  tcdm_pkg::tcdm_rsp_t arb_rsp;   // response with restored tag back to the arbiter
  tcdm_pkg::tcdm_req_t bank_req;  // untagged request into the bank
  tcdm_pkg::tcdm_rsp_t bank_rsp;  // raw bank response

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pipeline of arbiter then filter then bank
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  tcdm_rr_arbiter i_tcdm_rr_arbiter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear    (clear),
    .init_req (init_req),
    .init_rsp (init_rsp),
    .mem_req  (arb_req),
    .mem_rsp  (arb_rsp)
  );

  // placed directly in front of the bank where the latency is one cycle
  tcdm_r_id_filter i_tcdm_r_id_filter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear         (clear),
    .target_req    (arb_req),
    .target_rsp    (arb_rsp),
    .initiator_req (bank_req),
    .initiator_rsp (bank_rsp)
  );

  // memory contents survive a clear since the bank does not see it
  tcdm_sram_bank i_tcdm_sram_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req    (bank_req),
    .rsp    (bank_rsp)
  );

endmodule

`default_nettype wire
